//--- ip_core.f
rtl/ip_core_pkg.sv
rtl/key_event_if.sv
rtl/keyboard_scan.sv
rtl/key_event_fifo.sv
rtl/key_event_ctrl.sv
rtl/seven_tube.sv
rtl/beep_driver.sv
rtl/ip_core_top.sv
sim/ip_core_checker.sv
sim/ip_core_top_tb.sv

//--- rtl/beep_driver.sv
`timescale 1ns/1ps

module beep_driver #(
    parameter int BEEP_HALF    = ip_core_pkg::BEEP_HALF,
    parameter int BEEP_TOGGLES = ip_core_pkg::BEEP_TOGGLES
) (
    input  logic sys_clk,
    input  logic arst_n,
    input  logic start,
    output logic busy,
    output logic beep
);
    localparam int HALF_W = $clog2(BEEP_HALF);
    localparam int TOG_W  = $clog2(BEEP_TOGGLES);
    localparam logic [HALF_W-1:0] HALF_MAX = HALF_W'(BEEP_HALF - 1);
    localparam logic [TOG_W-1:0]  TOG_MAX  = TOG_W'(BEEP_TOGGLES - 1);

    logic [HALF_W-1:0] half_cnt;
    logic [TOG_W-1:0]  tog_cnt;  // Half periods already finished

    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            busy     <= 1'b0;
            beep     <= 1'b0;
            half_cnt <= '0;
            tog_cnt  <= '0;
        end else if (!busy) begin
            if (start) begin
                busy     <= 1'b1;
                beep     <= 1'b1;  // First edge opens the burst
                half_cnt <= '0;
                tog_cnt  <= '0;
            end
        end else if (half_cnt != HALF_MAX) begin
            half_cnt <= half_cnt + 1'b1;
        end else begin
            half_cnt <= '0;
            if (tog_cnt == TOG_MAX) begin
                busy <= 1'b0;  // Last half period was low
            end else begin
                beep    <= ~beep;
                tog_cnt <= tog_cnt + 1'b1;
            end
        end
    end

endmodule

//--- rtl/ip_core_pkg.sv
package ip_core_pkg;

    localparam int SCAN_TICKS    = 1000;  // Cycles per column slot
    localparam int FIFO_DEPTH    = 4;
    localparam int CREDIT_W      = 3;     // Holds 0 to FIFO_DEPTH
    localparam int DIGITS        = 8;
    localparam int REFRESH_TICKS = 500;   // Cycles per displayed digit
    localparam int BEEP_HALF     = 2500;  // Half period of the tone
    localparam int BEEP_TOGGLES  = 200;   // Edges per beep, even so it ends low

    typedef logic [3:0] key_code_t;  // Row * 4 + column

    typedef enum logic {
        KEY_PRESS   = 1'b0,
        KEY_RELEASE = 1'b1
    } key_kind_t;

    typedef struct packed {
        key_code_t code;
        key_kind_t kind;
    } key_event_t;

    // Active-low segments, bit 7 is dp and stays off
    function automatic logic [7:0] seg_of(input logic [3:0] hex);
        case (hex)
            4'h0:    seg_of = 8'hc0;
            4'h1:    seg_of = 8'hf9;
            4'h2:    seg_of = 8'ha4;
            4'h3:    seg_of = 8'hb0;
            4'h4:    seg_of = 8'h99;
            4'h5:    seg_of = 8'h92;
            4'h6:    seg_of = 8'h82;
            4'h7:    seg_of = 8'hf8;
            4'h8:    seg_of = 8'h80;
            4'h9:    seg_of = 8'h90;
            4'ha:    seg_of = 8'h88;
            4'hb:    seg_of = 8'h83;
            4'hc:    seg_of = 8'hc6;
            4'hd:    seg_of = 8'ha1;
            4'he:    seg_of = 8'h86;
            default: seg_of = 8'h8e;  // F
        endcase
    endfunction

endpackage

//--- rtl/ip_core_top.sv
`timescale 1ns/1ps

module ip_core_top #(
    parameter int SCAN_TICKS    = ip_core_pkg::SCAN_TICKS,
    parameter int REFRESH_TICKS = ip_core_pkg::REFRESH_TICKS,
    parameter int BEEP_HALF     = ip_core_pkg::BEEP_HALF,
    parameter int BEEP_TOGGLES  = ip_core_pkg::BEEP_TOGGLES
) (
    input  logic       sys_clk,
    input  logic       arst_n,
    input  logic [3:0] row_in,
    output logic [3:0] col_out,
    output logic       beep,
    output logic [1:0] led,
    output logic [2:0] sel,
    output logic [7:0] seg
);
    import ip_core_pkg::*;

    key_event_t        head;
    logic              empty;
    logic              pop;
    logic              start;
    logic              busy;
    key_code_t         digits [DIGITS];
    logic [DIGITS-1:0] digit_en;

    key_event_if ev_if (.sys_clk(sys_clk), .arst_n(arst_n));

    keyboard_scan #(.SCAN_TICKS(SCAN_TICKS)) keyboard_scan_inst (
        .sys_clk (sys_clk),
        .arst_n  (arst_n),
        .row_in  (row_in),
        .col_out (col_out),
        .ev      (ev_if.source)
    );

    key_event_fifo key_event_fifo_inst (
        .sys_clk (sys_clk),
        .arst_n  (arst_n),
        .ev      (ev_if.sink),
        .pop     (pop),
        .empty   (empty),
        .head    (head)
    );

    key_event_ctrl key_event_ctrl_inst (
        .sys_clk  (sys_clk),
        .arst_n   (arst_n),
        .empty    (empty),
        .head     (head),
        .pop      (pop),
        .busy     (busy),
        .start    (start),
        .digits   (digits),
        .digit_en (digit_en),
        .led      (led)
    );

    seven_tube #(.REFRESH_TICKS(REFRESH_TICKS)) seven_tube_inst (
        .sys_clk  (sys_clk),
        .arst_n   (arst_n),
        .digits   (digits),
        .digit_en (digit_en),
        .sel      (sel),
        .seg      (seg)
    );

    beep_driver #(
        .BEEP_HALF    (BEEP_HALF),
        .BEEP_TOGGLES (BEEP_TOGGLES)
    ) beep_driver_inst (
        .sys_clk (sys_clk),
        .arst_n  (arst_n),
        .start   (start),
        .busy    (busy),
        .beep    (beep)
    );

endmodule

//--- rtl/key_event_ctrl.sv
`timescale 1ns/1ps

module key_event_ctrl (
    input  logic                    sys_clk,
    input  logic                    arst_n,
    input  logic                    empty,
    input  ip_core_pkg::key_event_t head,
    output logic                    pop,
    input  logic                    busy,
    output logic                    start,
    output ip_core_pkg::key_code_t  digits [ip_core_pkg::DIGITS],
    output logic [ip_core_pkg::DIGITS-1:0] digit_en,
    output logic [1:0]              led
);
    import ip_core_pkg::*;

    logic is_press;

    assign is_press = (head.kind == KEY_PRESS);

    // Releases drain at once, presses wait for the tone to finish
    assign pop = !empty && (!is_press || (!busy && !start));

    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            start    <= 1'b0;
            digit_en <= '0;
            led      <= 2'b00;
        end else begin
            start <= pop && is_press;
            if (pop && is_press) begin
                digit_en <= {digit_en[DIGITS-2:0], 1'b1};
                led[0]   <= 1'b1;  // Key down
            end else if (pop) begin
                led[0] <= 1'b0;
                led[1] <= ~led[1];  // Flips on every release
            end
        end
    end

    // Newest code at digit 0
    always_ff @(posedge sys_clk) begin
        if (pop && is_press) begin
            digits[0] <= head.code;
            for (int i = 1; i < DIGITS; i++) begin
                digits[i] <= digits[i-1];
            end
        end
    end

endmodule

//--- rtl/key_event_fifo.sv
`timescale 1ns/1ps

module key_event_fifo (
    input  logic                   sys_clk,
    input  logic                   arst_n,
    key_event_if.sink              ev,
    input  logic                   pop,
    output logic                   empty,
    output ip_core_pkg::key_event_t head
);
    import ip_core_pkg::*;

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    key_event_t   mem [FIFO_DEPTH];
    logic [PTR_W:0] wr_ptr;  // Extra bit tells full from empty
    logic [PTR_W:0] rd_ptr;
    logic [PTR_W:0] fill;

    assign fill  = wr_ptr - rd_ptr;
    assign empty = (fill == '0);
    assign head  = mem[rd_ptr[PTR_W-1:0]];

    // No full check, the scanner never writes without a credit
    always_ff @(posedge sys_clk) begin
        if (ev.valid) begin
            mem[wr_ptr[PTR_W-1:0]] <= ev.evt;
        end
    end

    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
        end else if (ev.valid) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_ptr    <= '0;
            ev.credit <= 1'b0;
        end else begin
            ev.credit <= pop;  // Slot freed, hand the credit back
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

//--- rtl/key_event_if.sv
`timescale 1ns/1ps

interface key_event_if (
    input logic sys_clk,
    input logic arst_n
);
    import ip_core_pkg::*;

    logic       valid;   // One-cycle event strobe, costs one credit
    key_event_t evt;     // Event payload, qualified by valid
    logic       credit;  // One-cycle pulse per entry leaving the queue

    // Scanner side
    modport source (
        input  sys_clk, arst_n, credit,
        output valid, evt
    );

    // Queue side
    modport sink (
        input  sys_clk, arst_n, valid, evt,
        output credit
    );

endinterface

//--- rtl/keyboard_scan.sv
`timescale 1ns/1ps

module keyboard_scan #(
    parameter int SCAN_TICKS = ip_core_pkg::SCAN_TICKS
) (
    input  logic       sys_clk,
    input  logic       arst_n,
    input  logic [3:0] row_in,
    output logic [3:0] col_out,
    key_event_if.source ev
);
    import ip_core_pkg::*;

    localparam int TICK_W = $clog2(SCAN_TICKS);
    localparam logic [TICK_W-1:0] TICK_MAX = TICK_W'(SCAN_TICKS - 1);

    logic [TICK_W-1:0]   tick;
    logic [1:0]          col_idx;
    logic [3:0]          row_meta;
    logic [3:0]          row_sync;
    logic                slot_end;
    logic                row_hit;
    logic [1:0]          row_idx;
    key_code_t           code_now;
    logic                cand_valid;   // A key is under debounce or held
    key_code_t           cand_code;
    logic                held;
    logic [1:0]          stable_cnt;   // Consecutive matching sightings
    logic                pending;
    key_event_t          pend_evt;
    logic [CREDIT_W-1:0] credits;

    assign col_out  = ~(4'b0001 << col_idx);  // Single low bit walks the columns
    assign slot_end = (tick == TICK_MAX) && !pending;
    assign code_now = {row_idx, col_idx};

    // Lowest pressed row wins
    always_comb begin
        row_hit = 1'b0;
        row_idx = 2'd0;
        for (int i = 3; i >= 0; i--) begin
            if (!row_sync[i]) begin
                row_hit = 1'b1;
                row_idx = 2'(i);
            end
        end
    end

    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            row_meta <= 4'hf;
            row_sync <= 4'hf;
        end else begin
            row_meta <= row_in;  // Rows come from the keypad, not this clock
            row_sync <= row_meta;
        end
    end

    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            tick    <= '0;
            col_idx <= 2'd0;
        end else if (!pending) begin  // Hold the scan until the event leaves
            if (tick == TICK_MAX) begin
                tick    <= '0;
                col_idx <= col_idx + 2'd1;
            end else begin
                tick <= tick + 1'b1;
            end
        end
    end

    // First sighting plus two full scans confirms a change
    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            cand_valid <= 1'b0;
            cand_code  <= '0;
            held       <= 1'b0;
            stable_cnt <= 2'd0;
            pending    <= 1'b0;
            pend_evt   <= '0;
        end else begin
            if (ev.valid) begin
                pending <= 1'b0;
            end
            if (slot_end && !held) begin
                if (row_hit && cand_valid && cand_code == code_now) begin
                    if (stable_cnt == 2'd2) begin
                        held          <= 1'b1;
                        stable_cnt    <= 2'd0;
                        pending       <= 1'b1;
                        pend_evt.code <= code_now;
                        pend_evt.kind <= KEY_PRESS;
                    end else begin
                        stable_cnt <= stable_cnt + 2'd1;
                    end
                end else if (row_hit) begin
                    cand_valid <= 1'b1;  // New candidate restarts debounce
                    cand_code  <= code_now;
                    stable_cnt <= 2'd1;
                end else if (cand_valid && cand_code[1:0] == col_idx) begin
                    cand_valid <= 1'b0;  // Bounced away
                    stable_cnt <= 2'd0;
                end
            end else if (slot_end && col_idx == cand_code[1:0]) begin
                if (row_sync[cand_code[3:2]]) begin
                    if (stable_cnt == 2'd2) begin
                        held          <= 1'b0;
                        cand_valid    <= 1'b0;
                        stable_cnt    <= 2'd0;
                        pending       <= 1'b1;
                        pend_evt.code <= cand_code;
                        pend_evt.kind <= KEY_RELEASE;
                    end else begin
                        stable_cnt <= stable_cnt + 2'd1;
                    end
                end else begin
                    stable_cnt <= 2'd0;  // Still held
                end
            end
        end
    end

    assign ev.valid = pending && (credits != '0);
    assign ev.evt   = pend_evt;

    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            credits <= CREDIT_W'(FIFO_DEPTH);  // Whole queue is free
        end else if (ev.valid && !ev.credit) begin
            credits <= credits - 1'b1;
        end else if (!ev.valid && ev.credit) begin
            credits <= credits + 1'b1;
        end
    end

endmodule

//--- rtl/seven_tube.sv
`timescale 1ns/1ps

module seven_tube #(
    parameter int REFRESH_TICKS = ip_core_pkg::REFRESH_TICKS
) (
    input  logic                          sys_clk,
    input  logic                          arst_n,
    input  ip_core_pkg::key_code_t        digits [ip_core_pkg::DIGITS],
    input  logic [ip_core_pkg::DIGITS-1:0] digit_en,
    output logic [2:0]                    sel,
    output logic [7:0]                    seg
);
    import ip_core_pkg::*;

    localparam int CNT_W = $clog2(REFRESH_TICKS);
    localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(REFRESH_TICKS - 1);

    logic [CNT_W-1:0] refresh_cnt;

    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            refresh_cnt <= '0;
            sel         <= 3'd0;
        end else if (refresh_cnt == CNT_MAX) begin
            refresh_cnt <= '0;
            sel         <= sel + 3'd1;  // Next digit, wraps after 7
        end else begin
            refresh_cnt <= refresh_cnt + 1'b1;
        end
    end

    // Unwritten digits stay dark
    always_comb begin
        if (digit_en[sel]) begin
            seg = seg_of(digits[sel]);
        end else begin
            seg = 8'hff;
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# Compile the keypad panel testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module ip_core_top_tb -f ip_core.f

# Keep running past assertion errors so the testbench reports the outcome
out=$(./obj_dir/Vip_core_top_tb +verilator+error+limit+100 2>&1 || true)
echo "$out"
echo "$out" | grep -q "^PASS: all tests$"

//--- sim/ip_core_checker.sv
`timescale 1ns/1ps

module ip_core_checker (
    input logic                                     sys_clk,
    input logic                                     arst_n,
    input logic                                     valid,
    input logic                                     credit,
    input logic                                     pop,
    input logic                                     empty,
    input logic [$clog2(ip_core_pkg::FIFO_DEPTH):0] fill
);
    import ip_core_pkg::*;

    localparam int FILL_W = $clog2(FIFO_DEPTH) + 1;
    localparam logic [FILL_W-1:0] FULL = FILL_W'(FIFO_DEPTH);

    int unsigned fire_count = 0;  // Read by the testbench at the end

    // Credits must keep the scanner off a full queue
    assert property (@(posedge sys_clk) disable iff (!arst_n) valid |-> (fill != FULL))
        else begin
            fire_count = fire_count + 1;
            $error("valid arrived while the queue held %0d entries", FIFO_DEPTH);
        end

    assert property (@(posedge sys_clk) disable iff (!arst_n) pop |-> !empty)
        else begin
            fire_count = fire_count + 1;
            $error("pop asserted on an empty queue");
        end

    assert property (@(posedge sys_clk) disable iff (!arst_n) credit |-> $past(pop))
        else begin
            fire_count = fire_count + 1;
            $error("credit returned without a pop in the cycle before");
        end

endmodule

//--- sim/ip_core_top_tb.sv
`timescale 1ns/1ps

module ip_core_top_tb;
    import ip_core_pkg::*;

    localparam int SCAN_TICKS_TB    = 5;
    localparam int REFRESH_TICKS_TB = 4;
    localparam int BEEP_HALF_TB     = 3;
    localparam int BEEP_TOGGLES_TB  = 6;
    localparam int SCAN_CYCLES      = 4 * SCAN_TICKS_TB;  // One pass over all columns
    localparam int DEBOUNCE         = 2 * SCAN_CYCLES;
    localparam int BEEP_LEN         = BEEP_TOGGLES_TB * BEEP_HALF_TB;
    localparam int DISPLAY_CYCLES   = DIGITS * REFRESH_TICKS_TB;
    localparam int EVENT_LIMIT      = 4 * SCAN_CYCLES + 2 * BEEP_LEN + 16;
    localparam int KEYS             = 16;
    localparam int ROWS             = KEYS + 6;  // Every key, then rapid presses

    logic       sys_clk;
    logic       arst_n;
    logic [3:0] row_in;
    logic [3:0] col_out;
    logic       beep;
    logic [1:0] led;
    logic [2:0] sel;
    logic [7:0] seg;

    logic      key_down;
    key_code_t key_code;
    key_code_t tbl_code [ROWS];
    int        tbl_hold [ROWS];  // Cycles held after the press is seen
    int        tbl_gap  [ROWS];  // Idle cycles after the release is seen
    key_code_t hist [$];         // Expected display, newest first
    int        releases;
    int        watchdog_cycles;
    logic      prev_beep;
    int        burst_edges;
    int        low_run;
    int        burst_count;

    ip_core_top #(
        .SCAN_TICKS    (SCAN_TICKS_TB),
        .REFRESH_TICKS (REFRESH_TICKS_TB),
        .BEEP_HALF     (BEEP_HALF_TB),
        .BEEP_TOGGLES  (BEEP_TOGGLES_TB)
    ) u_dut (
        .sys_clk (sys_clk),
        .arst_n  (arst_n),
        .row_in  (row_in),
        .col_out (col_out),
        .beep    (beep),
        .led     (led),
        .sel     (sel),
        .seg     (seg)
    );

    bind key_event_fifo ip_core_checker u_checker (
        .sys_clk (sys_clk),
        .arst_n  (arst_n),
        .valid   (ev.valid),
        .credit  (ev.credit),
        .pop     (pop),
        .empty   (empty),
        .fill    (fill)
    );

    initial begin
        sys_clk = 1'b0;
        forever #50 sys_clk = ~sys_clk;
    end

    // Pressed key shorts its column onto its row
    always_comb begin
        row_in = 4'hf;
        if (key_down) begin
            row_in[key_code[3:2]] = col_out[key_code[1:0]];
        end
    end

    function automatic logic [31:0] next_random(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic key_code_t code_on_display(input logic [7:0] pattern);
        key_code_t found;
        found = 'x;
        for (int c = 0; c < KEYS; c++) begin
            if (seg_of(4'(c)) == pattern) begin
                found = key_code_t'(c);
            end
        end
        return found;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_code(input string name, input key_code_t got, input key_code_t want);
        if (got !== want) begin
            abort_run($sformatf("ERROR: %s got 0x%h expected 0x%h", name, got, want));
        end
    endtask

    task automatic check_seg(input string name, input logic [7:0] got, input logic [7:0] want);
        if (got !== want) begin
            abort_run($sformatf("ERROR: %s got 0x%h expected 0x%h", name, got, want));
        end
    endtask

    task automatic check_led(input logic [1:0] got, input logic [1:0] want);
        if (got !== want) begin
            abort_run($sformatf("ERROR: led got 0x%h expected 0x%h", got, want));
        end
    endtask

    task automatic check_beeps(input string name, input int got, input int want);
        if (got != want) begin
            abort_run($sformatf("ERROR: %s got 0x%h expected 0x%h", name, got, want));
        end
    endtask

    task automatic build_table();
        logic [31:0] lcg;
        int          span;
        int          total;
        lcg   = 32'h7b48cd43;
        total = 16 + 4 * DISPLAY_CYCLES + 4 * BEEP_LEN;
        for (int i = 0; i < ROWS; i++) begin
            span = (i < KEYS) ? 64 : 8;  // Rapid rows barely exceed the debounce
            lcg = next_random(lcg);
            tbl_code[i] = (i < KEYS) ? key_code_t'(i) : key_code_t'(lcg[27:24]);
            lcg = next_random(lcg);
            tbl_hold[i] = DEBOUNCE + int'(lcg[31:16]) % span;
            lcg = next_random(lcg);
            tbl_gap[i] = DEBOUNCE + int'(lcg[31:16]) % span;
            total += tbl_hold[i] + tbl_gap[i] + 2 * EVENT_LIMIT + DISPLAY_CYCLES;
            total += 2 * BEEP_LEN;
        end
        watchdog_cycles = total;
    endtask

    task automatic wait_led0(input logic level, input string what);
        int n;
        n = 0;
        while (led[0] !== level) begin
            @(negedge sys_clk);
            n++;
            if (n > EVENT_LIMIT) begin
                abort_run($sformatf("timeout: led[0] did not go to %0d after the %s", level, what));
            end
        end
    endtask

    task automatic wait_sel(input logic [2:0] digit);
        int n;
        n = 0;
        while (sel != digit) begin
            @(negedge sys_clk);
            n++;
            if (n > DISPLAY_CYCLES + 4) begin
                abort_run($sformatf("timeout: sel never selected digit %0d", digit));
            end
        end
    endtask

    task automatic check_display();
        logic [7:0] want;
        for (int d = 0; d < DIGITS; d++) begin
            wait_sel(3'(d));
            want = (d < hist.size()) ? seg_of(hist[d]) : 8'hff;  // Unwritten digit is dark
            check_seg($sformatf("seg on digit %0d", d), seg, want);
        end
    endtask

    // Counts edges per beep burst, a long quiet stretch closes the burst
    always @(negedge sys_clk) begin
        if (!arst_n) begin
            prev_beep   = 1'b0;
            burst_edges = 0;
            low_run     = 0;
            burst_count = 0;
        end else if (beep !== prev_beep) begin
            burst_edges++;
            low_run   = 0;
            prev_beep = beep;
        end else if (burst_edges != 0) begin
            low_run++;
            if (low_run > 2 * BEEP_HALF_TB) begin
                check_beeps("beep edges in one burst", burst_edges, BEEP_TOGGLES_TB);
                burst_count++;
                burst_edges = 0;
                low_run     = 0;
            end
        end
    end

    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge sys_clk);
        abort_run("timeout: the watchdog expired before the tests finished");
    end

    initial begin
        arst_n          = 1'b0;
        key_down        = 1'b0;
        key_code        = '0;
        releases        = 0;
        watchdog_cycles = 0;
        build_table();
        repeat (16) @(posedge sys_clk);
        @(negedge sys_clk);
        arst_n = 1'b1;

        check_code("col_out", col_out, 4'b1110);
        check_beeps("beep level", int'(beep), 0);
        check_led(led, 2'b00);
        check_display();

        for (int i = 0; i < ROWS; i++) begin
            @(negedge sys_clk);
            key_code = tbl_code[i];
            key_down = 1'b1;
            wait_led0(1'b1, $sformatf("press of key %h", tbl_code[i]));
            hist.push_front(tbl_code[i]);
            if (hist.size() > DIGITS) begin
                void'(hist.pop_back());
            end
            check_led(led, {releases[0], 1'b1});
            check_display();
            repeat (tbl_hold[i]) @(negedge sys_clk);
            check_led(led, {releases[0], 1'b1});  // Still held
            key_down = 1'b0;
            wait_led0(1'b0, $sformatf("release of key %h", tbl_code[i]));
            releases++;
            check_led(led, {releases[0], 1'b0});
            check_beeps("beep bursts", burst_count, i + 1);
            repeat (tbl_gap[i]) @(negedge sys_clk);
        end

        // Last eight codes, newest at digit 0
        for (int d = 0; d < DIGITS; d++) begin
            wait_sel(3'(d));
            check_code($sformatf("code on digit %0d", d), code_on_display(seg),
                       tbl_code[ROWS - 1 - d]);
        end
        check_beeps("beep bursts", burst_count, ROWS);

        if (u_dut.key_event_fifo_inst.u_checker.fire_count != 0) begin
            abort_run("the queue protocol assertions failed during the run");
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule
